/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_task_injector
DUT_TOP   ?= task_injector
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST OK$$'

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+.
inj_pkg.sv
task_header_builder.sv
header_store.sv
packet_sender.sv
task_injector.sv
inj_checker.sv
inj_props.sv
tb_task_injector.sv

/* header_store.sv */
`timescale 1ns/100ps
`default_nettype none

`include "inj_defs.svh"

module header_store
    import inj_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire logic     we_i,
    input  wire logic     clear_i,
    input  wire hdr_idx_t waddr_i,
    input  wire flit_t    wdata_i,
    input  wire hdr_idx_t raddr_i,
    output flit_t         rdata_o
);

    flit_t words_q [`HEADER_SIZE];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `HEADER_SIZE; i++) begin
                words_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `HEADER_SIZE; i++) begin
                if (we_i && waddr_i == hdr_idx_t'(i)) begin
                    words_q[i] <= wdata_i; // write wins over clear.
                end else if (clear_i) begin
                    words_q[i] <= '0;
                end
            end
        end
    end

    // indices past the header read as zero.
    always_comb begin
        if (raddr_i < hdr_idx_t'(`HEADER_SIZE)) begin
            rdata_o = words_q[raddr_i];
        end else begin
            rdata_o = '0;
        end
    end

endmodule

`default_nettype wire

/* inj_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "inj_defs.svh"

module inj_checker #(
    parameter int N_APP  = 2,
    parameter int N_TASK = 5
) (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic        active_i,
    input  wire logic        src_rx_i,
    input  wire logic        src_credit_i,
    input  wire logic        noc_tx_i,
    input  wire logic        noc_credit_i,
    input  wire logic [31:0] noc_data_i,
    input  wire logic [7:0]  app_id_i   [N_APP],
    input  wire logic [15:0] mapper_i   [N_APP],
    input  wire logic [15:0] target_i   [N_APP],
    input  wire logic [7:0]  task_cnt_i [N_APP],
    input  wire logic [31:0] text_i     [N_TASK],
    input  wire logic [31:0] data_i     [N_TASK],
    input  wire logic [31:0] bss_i      [N_TASK],
    input  wire logic [31:0] entry_i    [N_TASK],
    input  wire logic [31:0] seed_i     [N_TASK],
    output int               errors_o,
    output int               flits_o
);

    logic [31:0] exp_q [$];
    bit          code_q [$]; // flit is a code word.
    bit          built = 1'b0;
    int          err_cnt = 0;
    int          flit_cnt = 0;

    assign errors_o = err_cnt;
    assign flits_o  = flit_cnt;

    function automatic logic [31:0] code_word(input logic [31:0] seed, input int k);
        return seed ^ (k * 32'h9e3779b1);
    endfunction

    task automatic push_flit(input logic [31:0] flit, input bit is_code);
        exp_q.push_back(flit);
        code_q.push_back(is_code);
    endtask

    // one packet per task, in table order.
    task automatic build_expected();
        int          t;
        logic [31:0] len;
        t = 0;
        for (int a = 0; a < N_APP; a++) begin
            for (int i = 0; i < int'(task_cnt_i[a]); i++) begin
                len = (text_i[t] + data_i[t]) >> 2;
                push_flit({16'b0, target_i[a]}, 1'b0);
                push_flit(len + 32'd11, 1'b0);
                push_flit(`TASK_ALLOCATION, 1'b0);
                push_flit({16'b0, app_id_i[a], 8'(i)}, 1'b0);
                push_flit({16'b0, mapper_i[a]}, 1'b0);
                repeat (4) push_flit('0, 1'b0); // words 5 to 7 and mapper id.
                push_flit(data_i[t], 1'b0);
                push_flit(text_i[t], 1'b0);
                push_flit(bss_i[t], 1'b0);
                push_flit(entry_i[t], 1'b0);
                for (int k = 0; k < int'(len); k++) begin
                    push_flit(code_word(seed_i[t], k), 1'b1);
                end
                t++;
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (!built) begin
                build_expected();
                built = 1'b1;
            end
            if (noc_tx_i && !active_i) begin
                $display("%0t: noc_tx_o is high while no packet is expected", $time);
                err_cnt++;
            end
            // in the code phase a source word moves only together with a flit.
            if (code_q.size() > 0 && code_q[0] &&
                (src_rx_i && src_credit_i) != (noc_tx_i && noc_credit_i)) begin
                $display("%0t: source and NoC transfers differ in the code phase", $time);
                err_cnt++;
            end
            if (noc_tx_i && noc_credit_i) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: extra flit %h after the last expected one", $time,
                             noc_data_i);
                    err_cnt++;
                end else begin
                    if (noc_data_i !== exp_q[0]) begin
                        $display("FAILED %0t: flit %0d is %h, expected %h", $time,
                                 flit_cnt, noc_data_i, exp_q[0]);
                        err_cnt++;
                    end
                    void'(exp_q.pop_front());
                    void'(code_q.pop_front());
                    flit_cnt++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* inj_defs.svh */
`ifndef INJ_DEFS_SVH
`define INJ_DEFS_SVH

// flit and source word width.
`define FLIT_SIZE       32

// task allocation header length in flits.
`define HEADER_SIZE     13

// header word positions; 5, 6 and 7 stay zero.
`define HDR_TARGET      4'd0
`define HDR_PAYLOAD     4'd1
`define HDR_SERVICE     4'd2
`define HDR_TASK_ID     4'd3
`define HDR_MAPPER      4'd4
`define HDR_MAPPER_ID   4'd8
`define HDR_DATA_SZ     4'd9
`define HDR_TEXT_SZ     4'd10
`define HDR_BSS_SZ      4'd11
`define HDR_ENTRY       4'd12

`define TASK_ALLOCATION 32'h40

`define TASK_CNT_W      8

`endif

/* inj_pkg.sv */
`default_nettype none

`include "inj_defs.svh"

package inj_pkg;

    typedef logic [`FLIT_SIZE-1:0] flit_t;

    typedef logic [3:0] hdr_idx_t; // 13 header words.

    typedef enum logic [2:0] {
        BUILD_IDLE,  // waiting for the task count.
        BUILD_TXT,
        BUILD_DATA,
        BUILD_BSS,
        BUILD_ENTRY,
        BUILD_SEND,  // packet in flight.
        BUILD_NEXT
    } build_state_t;

    typedef enum logic [1:0] {
        SEND_IDLE,
        SEND_HEADER,
        SEND_CODE,
        SEND_DONE
    } send_state_t;

endpackage

`default_nettype wire

/* inj_props.sv */
`timescale 1ns/100ps
`default_nettype none

module inj_props
    import inj_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire send_state_t send_state_i,
    input  wire logic        noc_tx_i,
    input  wire logic        noc_credit_i,
    input  wire logic [31:0] noc_data_i,
    input  wire logic        src_credit_i
);

    int fail_cnt = 0; // failed assertions.

    idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
        send_state_i == SEND_IDLE |-> !noc_tx_i)
        else begin
            fail_cnt++;
            $error("noc_tx_o high while the sender idles");
        end

    // a stalled header flit holds its value.
    header_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (send_state_i == SEND_HEADER && noc_tx_i && !noc_credit_i) |=> $stable(noc_data_i))
        else begin
            fail_cnt++;
            $error("noc_data_o changed during a stalled header flit");
        end

    code_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (send_state_i == SEND_CODE && !noc_credit_i) |-> !src_credit_i)
        else begin
            fail_cnt++;
            $error("src_credit_o high in the code phase without NoC credit");
        end

endmodule

bind task_injector inj_props i_props (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .send_state_i (i_sender.state_q),
    .noc_tx_i     (noc_tx_o),
    .noc_credit_i (noc_credit_i),
    .noc_data_i   (noc_data_o),
    .src_credit_i (src_credit_o)
);

`default_nettype wire

/* packet_sender.sv */
`timescale 1ns/100ps
`default_nettype none

`include "inj_defs.svh"

module packet_sender
    import inj_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  send_start_i,
    input  wire flit_t code_len_i,
    input  wire flit_t hdr_rdata_i,
    input  wire logic  src_rx_i,
    input  wire flit_t src_data_i,
    input  wire logic  noc_credit_i,
    output hdr_idx_t   hdr_raddr_o,
    output logic       noc_tx_o,
    output flit_t      noc_data_o,
    output logic       code_ready_o,
    output logic       send_done_o
);

    send_state_t state_q, state_d;

    hdr_idx_t hdr_idx_q;
    flit_t    code_cnt_q; // code words forwarded so far.
    logic     noc_fire;
    logic     hdr_last;
    logic     code_last;

    assign noc_fire    = noc_tx_o && noc_credit_i;
    assign hdr_last    = hdr_idx_q == hdr_idx_t'(`HEADER_SIZE - 1);
    assign code_last   = code_cnt_q == code_len_i - 1'b1;
    assign hdr_raddr_o = hdr_idx_q;
    assign send_done_o = state_q == SEND_DONE;

    always_comb begin
        noc_tx_o     = 1'b0;
        noc_data_o   = hdr_rdata_i;
        code_ready_o = 1'b0;
        case (state_q)
            SEND_HEADER: noc_tx_o = 1'b1;
            SEND_CODE: begin
                // source words pass straight through.
                noc_tx_o     = src_rx_i;
                noc_data_o   = src_data_i;
                code_ready_o = noc_credit_i;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEND_IDLE: begin
                if (send_start_i) begin
                    state_d = SEND_HEADER;
                end
            end
            SEND_HEADER: begin
                if (noc_fire && hdr_last) begin
                    state_d = (code_len_i == '0) ? SEND_DONE : SEND_CODE;
                end
            end
            SEND_CODE: begin
                if (noc_fire && code_last) begin
                    state_d = SEND_DONE;
                end
            end
            default: state_d = SEND_IDLE; // done lasts one cycle.
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= SEND_IDLE;
            hdr_idx_q  <= '0;
            code_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == SEND_IDLE) begin
                hdr_idx_q  <= '0;
                code_cnt_q <= '0;
            end else if (state_q == SEND_HEADER && noc_fire && !hdr_last) begin
                hdr_idx_q <= hdr_idx_q + 1'b1;
            end else if (state_q == SEND_CODE && noc_fire) begin
                code_cnt_q <= code_cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* task_header_builder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "inj_defs.svh"

module task_header_builder
    import inj_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic        src_rx_i,
    input  wire flit_t       src_data_i,
    input  wire logic [15:0] target_address_i,
    input  wire logic [15:0] mapper_address_i,
    input  wire logic [7:0]  app_id_i,
    input  wire logic        code_ready_i,
    input  wire logic        send_done_i,
    output logic             src_credit_o,
    output logic             hdr_we_o,
    output logic             hdr_clear_o,
    output hdr_idx_t         hdr_waddr_o,
    output flit_t            hdr_wdata_o,
    output logic             send_start_o,
    output flit_t            code_len_o
);

    build_state_t state_q, state_d;

    logic [`TASK_CNT_W-1:0] task_cnt_q;
    logic [`TASK_CNT_W-1:0] task_idx_q;
    logic [2:0]             wr_step_q;
    logic                   send_start_q;
    flit_t                  len_sum_q;  // text + data bytes.
    flit_t                  entry_q;
    logic [15:0]            target_q;
    logic                   src_fire;
    logic                   last_task;

    assign src_fire     = src_rx_i && src_credit_o;
    assign last_task    = (task_idx_q + 1'b1) == task_cnt_q;
    assign code_len_o   = {2'b00, len_sum_q[`FLIT_SIZE-1:2]}; // bytes to words.
    assign send_start_o = send_start_q;

    always_comb begin
        case (state_q)
            BUILD_IDLE, BUILD_TXT, BUILD_DATA, BUILD_BSS, BUILD_ENTRY: src_credit_o = 1'b1;
            BUILD_SEND: src_credit_o = code_ready_i;
            default:    src_credit_o = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            BUILD_IDLE:  if (src_fire && src_data_i[`TASK_CNT_W-1:0] != '0) state_d = BUILD_TXT;
            BUILD_TXT:   if (src_fire) state_d = BUILD_DATA;
            BUILD_DATA:  if (src_fire) state_d = BUILD_BSS;
            BUILD_BSS:   if (src_fire) state_d = BUILD_ENTRY;
            BUILD_ENTRY: if (src_fire) state_d = BUILD_SEND;
            BUILD_SEND:  if (send_done_i) state_d = BUILD_NEXT;
            BUILD_NEXT:  state_d = last_task ? BUILD_IDLE : BUILD_TXT;
            default:     state_d = BUILD_IDLE;
        endcase
    end

    // size words go in as they arrive. the fixed fields follow in BUILD_SEND,
    // word k is written before the sender can reach index k.
    always_comb begin
        hdr_we_o    = 1'b0;
        hdr_clear_o = 1'b0;
        hdr_waddr_o = `HDR_TARGET;
        hdr_wdata_o = '0;
        case (state_q)
            BUILD_TXT: begin
                hdr_we_o    = src_fire;
                hdr_clear_o = src_fire; // new header.
                hdr_waddr_o = `HDR_TEXT_SZ;
                hdr_wdata_o = src_data_i;
            end
            BUILD_DATA: begin
                hdr_we_o    = src_fire;
                hdr_waddr_o = `HDR_DATA_SZ;
                hdr_wdata_o = src_data_i;
            end
            BUILD_BSS: begin
                hdr_we_o    = src_fire;
                hdr_waddr_o = `HDR_BSS_SZ;
                hdr_wdata_o = src_data_i;
            end
            BUILD_ENTRY: begin
                hdr_we_o    = src_fire;
                hdr_waddr_o = `HDR_PAYLOAD;
                hdr_wdata_o = code_len_o + flit_t'(`HEADER_SIZE - 2);
            end
            BUILD_SEND: begin
                hdr_we_o = 1'b1;
                case (wr_step_q)
                    3'd0: hdr_wdata_o = {16'b0, target_q};
                    3'd1: begin
                        hdr_waddr_o = `HDR_SERVICE;
                        hdr_wdata_o = `TASK_ALLOCATION;
                    end
                    3'd2: begin
                        hdr_waddr_o = `HDR_TASK_ID;
                        hdr_wdata_o = {16'b0, app_id_i, task_idx_q};
                    end
                    3'd3: begin
                        hdr_waddr_o = `HDR_MAPPER;
                        hdr_wdata_o = {16'b0, mapper_address_i};
                    end
                    3'd4: hdr_waddr_o = `HDR_MAPPER_ID; // always zero.
                    3'd5: begin
                        hdr_waddr_o = `HDR_ENTRY;
                        hdr_wdata_o = entry_q;
                    end
                    default: hdr_we_o = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= BUILD_IDLE;
            task_cnt_q   <= '0;
            task_idx_q   <= '0;
            wr_step_q    <= '0;
            send_start_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            send_start_q <= (state_q == BUILD_ENTRY) && src_fire;
            if (state_q == BUILD_IDLE && src_fire) begin
                task_cnt_q <= src_data_i[`TASK_CNT_W-1:0];
                task_idx_q <= '0;
            end else if (state_q == BUILD_NEXT && !last_task) begin
                task_idx_q <= task_idx_q + 1'b1;
            end
            if (state_q == BUILD_ENTRY && src_fire) begin
                wr_step_q <= '0;
            end else if (state_q == BUILD_SEND && wr_step_q != 3'd6) begin
                wr_step_q <= wr_step_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (src_fire) begin
            case (state_q)
                BUILD_TXT: begin
                    len_sum_q <= src_data_i;
                    target_q  <= target_address_i;
                end
                BUILD_DATA:  len_sum_q <= len_sum_q + src_data_i;
                BUILD_ENTRY: entry_q   <= src_data_i;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* task_injector.sv */
`timescale 1ns/100ps
`default_nettype none

module task_injector
    import inj_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic        src_rx_i,
    output logic             src_credit_o,
    input  wire flit_t       src_data_i,
    input  wire logic [15:0] target_address_i,
    input  wire logic [15:0] mapper_address_i,
    input  wire logic [7:0]  app_id_i,
    output logic             noc_tx_o,
    input  wire logic        noc_credit_i,
    output flit_t            noc_data_o
);

    logic     hdr_we;
    logic     hdr_clear;
    hdr_idx_t hdr_waddr;
    flit_t    hdr_wdata;
    hdr_idx_t hdr_raddr;
    flit_t    hdr_rdata;
    logic     send_start;
    logic     send_done;
    flit_t    code_len;
    logic     code_ready;

    task_header_builder i_builder (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .src_rx_i         (src_rx_i),
        .src_data_i       (src_data_i),
        .target_address_i (target_address_i),
        .mapper_address_i (mapper_address_i),
        .app_id_i         (app_id_i),
        .code_ready_i     (code_ready),
        .send_done_i      (send_done),
        .src_credit_o     (src_credit_o),
        .hdr_we_o         (hdr_we),
        .hdr_clear_o      (hdr_clear),
        .hdr_waddr_o      (hdr_waddr),
        .hdr_wdata_o      (hdr_wdata),
        .send_start_o     (send_start),
        .code_len_o       (code_len)
    );

    header_store i_store (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .we_i    (hdr_we),
        .clear_i (hdr_clear),
        .waddr_i (hdr_waddr),
        .wdata_i (hdr_wdata),
        .raddr_i (hdr_raddr),
        .rdata_o (hdr_rdata)
    );

    packet_sender i_sender (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .send_start_i (send_start),
        .code_len_i   (code_len),
        .hdr_rdata_i  (hdr_rdata),
        .src_rx_i     (src_rx_i),
        .src_data_i   (src_data_i),
        .noc_credit_i (noc_credit_i),
        .hdr_raddr_o  (hdr_raddr),
        .noc_tx_o     (noc_tx_o),
        .noc_data_o   (noc_data_o),
        .code_ready_o (code_ready),
        .send_done_o  (send_done)
    );

endmodule

`default_nettype wire

/* tb_task_injector.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_task_injector;

    localparam int N_APP  = 2;
    localparam int N_TASK = 5;
    localparam int LIMIT  = 1000; // cycles per wait.

    logic        clk;
    logic        rst_n;
    logic        src_rx;
    logic        src_credit;
    logic [31:0] src_data;
    logic [15:0] target_address;
    logic [15:0] mapper_address;
    logic [7:0]  app_id;
    logic        noc_tx;
    logic        noc_credit;
    logic [31:0] noc_data;
    logic        active;
    int          errors;
    int          flits;
    int          seed = 32'h3e05f2d2;
    bit          timed_out = 1'b0;

    // applications, then all their tasks in order.
    logic [7:0]  app_id_tbl   [N_APP]  = '{8'h11, 8'h2a};
    logic [15:0] mapper_tbl   [N_APP]  = '{16'h0001, 16'h0203};
    logic [15:0] target_tbl   [N_APP]  = '{16'h0102, 16'h0304};
    logic [7:0]  task_cnt_tbl [N_APP]  = '{8'd3, 8'd2};
    logic [31:0] text_tbl     [N_TASK] = '{32'd16, 32'd0, 32'd20, 32'd6, 32'd40};
    logic [31:0] data_tbl     [N_TASK] = '{32'd8, 32'd0, 32'd4, 32'd10, 32'd0};
    logic [31:0] bss_tbl      [N_TASK] = '{32'd4, 32'd12, 32'd0, 32'd8, 32'd16};
    logic [31:0] entry_tbl    [N_TASK] = '{32'h100, 32'h0, 32'h80, 32'h40, 32'h200};
    logic [31:0] seed_tbl     [N_TASK] = '{32'h12345678, 32'h0badf00d, 32'h5555aaaa,
                                           32'hc001d00d, 32'h7e570001};

    task_injector i_dut (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .src_rx_i         (src_rx),
        .src_credit_o     (src_credit),
        .src_data_i       (src_data),
        .target_address_i (target_address),
        .mapper_address_i (mapper_address),
        .app_id_i         (app_id),
        .noc_tx_o         (noc_tx),
        .noc_credit_i     (noc_credit),
        .noc_data_o       (noc_data)
    );

    inj_checker #(.N_APP(N_APP), .N_TASK(N_TASK)) i_chk (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .active_i     (active),
        .src_rx_i     (src_rx),
        .src_credit_i (src_credit),
        .noc_tx_i     (noc_tx),
        .noc_credit_i (noc_credit),
        .noc_data_i   (noc_data),
        .app_id_i     (app_id_tbl),
        .mapper_i     (mapper_tbl),
        .target_i     (target_tbl),
        .task_cnt_i   (task_cnt_tbl),
        .text_i       (text_tbl),
        .data_i       (data_tbl),
        .bss_i        (bss_tbl),
        .entry_i      (entry_tbl),
        .seed_i       (seed_tbl),
        .errors_o     (errors),
        .flits_o      (flits)
    );

    function automatic logic [31:0] code_word(input logic [31:0] word_seed, input int k);
        return word_seed ^ (k * 32'h9e3779b1);
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        noc_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1 noc_credit = ($random(seed) & 3) != 0; // about three in four.
        end
    end

    // offers one word and returns 1 ns after the edge that took it.
    task automatic send_word(input logic [31:0] word);
        int cycles;
        cycles = 0;
        if (timed_out) return;
        src_rx   = 1'b1;
        src_data = word;
        @(negedge clk);
        while (!src_credit) begin
            cycles++;
            if (cycles > LIMIT) begin
                $display("%0t: source word %h was never accepted", $time, word);
                timed_out = 1'b1;
                src_rx    = 1'b0;
                return;
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1 src_rx = 1'b0;
    endtask

    task automatic wait_flits(input int count);
        int cycles;
        cycles = 0;
        if (timed_out) return;
        while (flits < count) begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) begin
                $display("%0t: only %0d of %0d flits arrived", $time, flits, count);
                timed_out = 1'b1;
                return;
            end
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        int total;
        int len;
        int t;
        total          = 0;
        t              = 0;
        rst_n          = 1'b0;
        src_rx         = 1'b0;
        src_data       = '0;
        target_address = '0;
        mapper_address = '0;
        app_id         = '0;
        active         = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (5) @(posedge clk); // noc_tx_o must stay low here.
        #1 active = 1'b1;
        for (int a = 0; a < N_APP; a++) begin
            app_id         = app_id_tbl[a];
            mapper_address = mapper_tbl[a];
            target_address = target_tbl[a];
            send_word(32'(task_cnt_tbl[a]));
            for (int i = 0; i < int'(task_cnt_tbl[a]); i++) begin
                send_word(text_tbl[t]);
                send_word(data_tbl[t]);
                send_word(bss_tbl[t]);
                send_word(entry_tbl[t]);
                len = int'((text_tbl[t] + data_tbl[t]) >> 2);
                for (int k = 0; k < len; k++) begin
                    send_word(code_word(seed_tbl[t], k));
                    if (k % 3 == 2) begin
                        @(posedge clk); // idle source cycle.
                        #1;
                    end
                end
                total += 13 + len;
                t++;
            end
            wait_flits(total); // app inputs hold until its last packet is out.
        end
        active = 1'b0;
        if (!timed_out) begin
            // empty applications. nothing may follow the last packet.
            src_rx   = 1'b1;
            src_data = '0;
            repeat (20) @(posedge clk);
            #1 src_rx = 1'b0;
        end
        $display("checker errors %0d, assertion failures %0d, flits %0d, timeout %0d",
                 errors, i_dut.i_props.fail_cnt, flits, timed_out);
        if (errors == 0 && i_dut.i_props.fail_cnt == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
